// File: Makefile
SRCS := $(wildcard design/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vinterco_tb: $(SRCS) sources.f
	verilator --binary --timing --assert --top-module interco_tb -Mdir obj_dir -f sources.f

run: obj_dir/Vinterco_tb
	./obj_dir/Vinterco_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/interco_pkg.sv
/*
 * Shared sizes, cacheable window, channel structs and enums of the read
 * interconnect. Design and test files refer to these by scoped name.
 */

`default_nettype none

package interco_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NumSlvPorts  = 4;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned SlvIdWidth   = 2;
  localparam int unsigned PortIdxWidth = $clog2(NumSlvPorts);
  localparam int unsigned IntIdWidth   = PortIdxWidth + SlvIdWidth; // Port index on top

  // Direct-mapped cache with one word per line
  localparam int unsigned LineCount    = 16;
  localparam int unsigned IndexWidth   = $clog2(LineCount);
  localparam int unsigned ByteOffWidth = $clog2(DataWidth / 8);
  localparam int unsigned TagWidth     = AddrWidth - IndexWidth - ByteOffWidth;

  // Cacheable window, base inclusive and limit exclusive
  localparam logic [AddrWidth-1:0] CacheBase  = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] CacheLimit = 32'h1000_1000;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [SlvIdWidth-1:0]   slv_id_t;
  typedef logic [IntIdWidth-1:0]   int_id_t;
  typedef logic [PortIdxWidth-1:0] port_idx_t;
  typedef logic [IndexWidth-1:0]   index_t;
  typedef logic [TagWidth-1:0]     tag_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } rresp_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_RESPOND,
    ST_FETCH_AR,
    ST_FETCH_R
  } cache_state_e;

  // Held AR beat, used by the spill register and the cache request register
  typedef struct packed {
    int_id_t id;
    addr_t   addr;
  } int_ar_t;

  // Requester side
  typedef struct packed {
    logic    ar_valid;
    slv_id_t ar_id;
    addr_t   ar_addr;
    logic    r_ready;
  } slv_req_t;

  typedef struct packed {
    logic    ar_ready;
    logic    r_valid;
    slv_id_t r_id;
    data_t   r_data;
    rresp_e  r_resp;
  } slv_rsp_t;

  // Internal and master side, port index prepended to the ID
  typedef struct packed {
    logic    ar_valid;
    int_id_t ar_id;
    addr_t   ar_addr;
    logic    r_ready;
  } int_req_t;

  typedef struct packed {
    logic    ar_ready;
    logic    r_valid;
    int_id_t r_id;
    data_t   r_data;
    rresp_e  r_resp;
  } int_rsp_t;

endpackage

`default_nettype wire

// File: design/interco_top.sv
/*
 * One level of the read interconnect. Four requesting ports pass the
 * round-robin multiplexer and the read-only cache to one master port.
 */

`timescale 1ns/1ns
`default_nettype none

module interco_top (
  input  wire logic                                              clk_i,
  input  wire logic                                              arst_n_i,
  input  interco_pkg::slv_req_t [interco_pkg::NumSlvPorts-1:0] slv_req_i,
  output interco_pkg::slv_rsp_t [interco_pkg::NumSlvPorts-1:0] slv_rsp_o,
  output interco_pkg::int_req_t                                  mst_req_o,
  input  interco_pkg::int_rsp_t                                  mst_rsp_i
);

  // Multiplexer to cache
  interco_pkg::int_req_t int_req;
  interco_pkg::int_rsp_t int_rsp;

  // Cache control to store
  interco_pkg::addr_t lookup_addr;
  logic               hit;
  interco_pkg::data_t hit_data;
  logic               fill_en;
  interco_pkg::data_t fill_data;

  read_mux read_mux_i (
    .clk_i     (clk_i    ),
    .arst_n_i  (arst_n_i ),
    .slv_req_i (slv_req_i),
    .slv_rsp_o (slv_rsp_o),
    .int_req_o (int_req  ),
    .int_rsp_i (int_rsp  )
  );

  ro_cache_ctrl ro_cache_ctrl_i (
    .clk_i         (clk_i      ),
    .arst_n_i      (arst_n_i   ),
    .int_req_i     (int_req    ),
    .int_rsp_o     (int_rsp    ),
    .mst_req_o     (mst_req_o  ),
    .mst_rsp_i     (mst_rsp_i  ),
    .lookup_addr_o (lookup_addr),
    .hit_i         (hit        ),
    .hit_data_i    (hit_data   ),
    .fill_en_o     (fill_en    ),
    .fill_data_o   (fill_data  )
  );

  ro_cache_store ro_cache_store_i (
    .clk_i         (clk_i      ),
    .arst_n_i      (arst_n_i   ),
    .lookup_addr_i (lookup_addr),
    .hit_o         (hit        ),
    .hit_data_o    (hit_data   ),
    .fill_en_i     (fill_en    ),
    .fill_data_i   (fill_data  )
  );

endmodule

`default_nettype wire

// File: design/read_mux.sv
/*
 * Round-robin read multiplexer. Merges the AR channels of all requesting
 * ports into one spill register, widening the ID with the port index, and
 * steers R beats back to the port named by the upper ID bits.
 */

`timescale 1ns/1ns
`default_nettype none

module read_mux (
  input  wire logic                                              clk_i,
  input  wire logic                                              arst_n_i,
  input  interco_pkg::slv_req_t [interco_pkg::NumSlvPorts-1:0] slv_req_i,
  output interco_pkg::slv_rsp_t [interco_pkg::NumSlvPorts-1:0] slv_rsp_o,
  output interco_pkg::int_req_t                                  int_req_o,
  input  interco_pkg::int_rsp_t                                  int_rsp_i
);

  interco_pkg::port_idx_t rr_ptr_q;   // First port to look at
  interco_pkg::port_idx_t gnt_idx;
  logic                   gnt_valid;
  logic                   spill_valid_q;
  interco_pkg::int_ar_t   spill_q;
  logic                   spill_ready;
  logic                   ar_take;
  interco_pkg::port_idx_t r_port;

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////////////////////

  // Search starts at the port after the last grant
  always_comb begin : arb_search
    interco_pkg::port_idx_t idx;
    gnt_valid = 1'b0;
    gnt_idx   = rr_ptr_q;
    idx       = rr_ptr_q;
    for (int unsigned k = 0; k < interco_pkg::NumSlvPorts; k++) begin
      idx = rr_ptr_q + interco_pkg::port_idx_t'(k);
      if (!gnt_valid && slv_req_i[idx].ar_valid) begin
        gnt_valid = 1'b1;
        gnt_idx   = idx;
      end
    end
  end

  assign spill_ready = !spill_valid_q || int_rsp_i.ar_ready; // Empty or draining
  assign ar_take     = gnt_valid && spill_ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      spill_valid_q <= 1'b0;
      rr_ptr_q      <= '0;
    end else if (ar_take) begin
      spill_valid_q <= 1'b1;
      rr_ptr_q      <= gnt_idx + 1'b1;
    end else if (int_rsp_i.ar_ready) begin
      spill_valid_q <= 1'b0;
    end
  end

  // Spill payload, ID widened with the granted port
  always_ff @(posedge clk_i) begin
    if (ar_take) begin
      spill_q.id   <= {gnt_idx, slv_req_i[gnt_idx].ar_id};
      spill_q.addr <= slv_req_i[gnt_idx].ar_addr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Internal side and response routing
  ////////////////////////////////////////////////////////////////////////////

  assign r_port = int_rsp_i.r_id[interco_pkg::IntIdWidth-1 -: interco_pkg::PortIdxWidth];

  always_comb begin
    int_req_o.ar_valid = spill_valid_q;
    int_req_o.ar_id    = spill_q.id;
    int_req_o.ar_addr  = spill_q.addr;
    int_req_o.r_ready  = slv_req_i[r_port].r_ready; // Ready from the addressed port
  end

  always_comb begin
    for (int unsigned p = 0; p < interco_pkg::NumSlvPorts; p++) begin
      slv_rsp_o[p].ar_ready = ar_take && (gnt_idx == interco_pkg::port_idx_t'(p));
      slv_rsp_o[p].r_valid  = int_rsp_i.r_valid && (r_port == interco_pkg::port_idx_t'(p));
      slv_rsp_o[p].r_id     = int_rsp_i.r_id[interco_pkg::SlvIdWidth-1:0];
      slv_rsp_o[p].r_data   = int_rsp_i.r_data;
      slv_rsp_o[p].r_resp   = int_rsp_i.r_resp;
    end
  end

endmodule

`default_nettype wire

// File: design/ro_cache_ctrl.sv
/*
 * Control of the blocking read-only cache. Takes one internal read at a
 * time, answers window hits from the store and forwards misses and
 * out-of-window reads to the master port, filling OKAY window responses.
 */

`timescale 1ns/1ns
`default_nettype none

module ro_cache_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  // Internal side, from the multiplexer
  input  interco_pkg::int_req_t      int_req_i,
  output interco_pkg::int_rsp_t      int_rsp_o,
  // Master port
  output interco_pkg::int_req_t      mst_req_o,
  input  interco_pkg::int_rsp_t      mst_rsp_i,
  // Store access
  output interco_pkg::addr_t         lookup_addr_o,
  input  wire logic                  hit_i,
  input  interco_pkg::data_t         hit_data_i,
  output logic                       fill_en_o,
  output interco_pkg::data_t         fill_data_o
);

  interco_pkg::cache_state_e state_q;
  interco_pkg::cache_state_e state_d;
  interco_pkg::int_ar_t      req_q;       // Request being served
  logic                      in_window;
  logic                      ar_hs;
  logic                      responding;
  logic                      fetching_r;

  assign ar_hs      = (state_q == interco_pkg::ST_IDLE) && int_req_i.ar_valid;
  assign responding = (state_q == interco_pkg::ST_RESPOND);
  assign fetching_r = (state_q == interco_pkg::ST_FETCH_R);

  // Window check on the held address
  assign in_window = (req_q.addr >= interco_pkg::CacheBase) &&
                     (req_q.addr <  interco_pkg::CacheLimit);

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      req_q.id   <= int_req_i.ar_id;
      req_q.addr <= int_req_i.ar_addr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      interco_pkg::ST_IDLE: begin
        if (int_req_i.ar_valid) state_d = interco_pkg::ST_LOOKUP;
      end
      interco_pkg::ST_LOOKUP: begin
        // Store answers combinationally on the held address
        if (in_window && hit_i) begin
          state_d = interco_pkg::ST_RESPOND;
        end else begin
          state_d = interco_pkg::ST_FETCH_AR;
        end
      end
      interco_pkg::ST_RESPOND: begin
        if (int_req_i.r_ready) state_d = interco_pkg::ST_IDLE;
      end
      interco_pkg::ST_FETCH_AR: begin
        if (mst_rsp_i.ar_ready) state_d = interco_pkg::ST_FETCH_R;
      end
      interco_pkg::ST_FETCH_R: begin
        if (mst_rsp_i.r_valid && int_req_i.r_ready) state_d = interco_pkg::ST_IDLE;
      end
      default: state_d = interco_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= interco_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Channel outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    int_rsp_o.ar_ready = (state_q == interco_pkg::ST_IDLE);
    int_rsp_o.r_valid  = responding || (fetching_r && mst_rsp_i.r_valid);
    if (responding) begin
      int_rsp_o.r_id   = req_q.id;
      int_rsp_o.r_data = hit_data_i;          // Line stays put while responding
      int_rsp_o.r_resp = interco_pkg::RESP_OKAY;
    end else begin
      int_rsp_o.r_id   = mst_rsp_i.r_id;      // Downstream response passed back
      int_rsp_o.r_data = mst_rsp_i.r_data;
      int_rsp_o.r_resp = mst_rsp_i.r_resp;
    end
  end

  // Forwarded reads keep their internal ID
  always_comb begin
    mst_req_o.ar_valid = (state_q == interco_pkg::ST_FETCH_AR);
    mst_req_o.ar_id    = req_q.id;
    mst_req_o.ar_addr  = req_q.addr;
    mst_req_o.r_ready  = fetching_r && int_req_i.r_ready;
  end

  assign lookup_addr_o = req_q.addr;

  // Fill only at the downstream R transfer, OKAY and inside the window
  assign fill_en_o   = fetching_r && mst_rsp_i.r_valid && int_req_i.r_ready &&
                       in_window && (mst_rsp_i.r_resp == interco_pkg::RESP_OKAY);
  assign fill_data_o = mst_rsp_i.r_data;

endmodule

`default_nettype wire

// File: design/ro_cache_store.sv
/*
 * Storage of the direct-mapped read-only cache. Valid, tag and data
 * arrays with a combinational lookup and a clocked one-word line fill.
 */

`timescale 1ns/1ns
`default_nettype none

module ro_cache_store (
  input  wire logic          clk_i,
  input  wire logic          arst_n_i,
  input  interco_pkg::addr_t lookup_addr_i,
  output logic               hit_o,
  output interco_pkg::data_t hit_data_o,
  input  wire logic          fill_en_i,
  input  interco_pkg::data_t fill_data_i
);

  interco_pkg::index_t index;
  interco_pkg::tag_t   tag;

  logic [interco_pkg::LineCount-1:0]                       valid_q;
  logic [interco_pkg::LineCount-1:0][interco_pkg::TagWidth-1:0] tag_q;
  interco_pkg::data_t                                      data_q [interco_pkg::LineCount];

  ////////////////////////////////////////////////////////////////////////////
  // Address split
  ////////////////////////////////////////////////////////////////////////////

  // Byte offset dropped, word index below the tag
  assign index = lookup_addr_i[interco_pkg::ByteOffWidth +: interco_pkg::IndexWidth];
  assign tag   = lookup_addr_i[interco_pkg::AddrWidth-1 -: interco_pkg::TagWidth];

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  assign hit_o      = valid_q[index] && (tag_q[index] == tag);
  assign hit_data_o = data_q[index];   // Only meaningful with hit_o

  ////////////////////////////////////////////////////////////////////////////
  // Fill
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      tag_q   <= '0;
    end else if (fill_en_i) begin
      valid_q[index] <= 1'b1;
      tag_q[index]   <= tag;
    end
  end

  // Data array
  always_ff @(posedge clk_i) begin
    if (fill_en_i) begin
      data_q[index] <= fill_data_i;
    end
  end

endmodule

`default_nettype wire

// File: sources.f
design/interco_pkg.sv
design/read_mux.sv
design/ro_cache_store.sv
design/ro_cache_ctrl.sv
design/interco_top.sv
tests/interco_asserts.sv
tests/interco_tb.sv

// File: tests/interco_asserts.sv
/*
 * Handshake assertions for one request/response channel pair. Bound to the
 * multiplexer's internal side and to the cache's master port.
 */

`timescale 1ns/1ns
`default_nettype none

module interco_asserts (
  input  wire logic                                  clk_i,
  input  wire logic                                  arst_n_i,
  input  interco_pkg::int_req_t                      req_i,
  input  interco_pkg::int_rsp_t                      rsp_i,
  input  wire logic [interco_pkg::NumSlvPorts-1:0]   grant_i
);

  logic pending_q;  // AR accepted, R not yet returned

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
    end else if (req_i.ar_valid && rsp_i.ar_ready) begin
      pending_q <= 1'b1;
    end else if (rsp_i.r_valid && req_i.r_ready) begin
      pending_q <= 1'b0;
    end
  end

  ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i.ar_valid && !rsp_i.ar_ready |=>
      req_i.ar_valid && $stable(req_i.ar_id) && $stable(req_i.ar_addr))
    else $error("AR payload changed before its transfer");

  r_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_i.r_valid && !req_i.r_ready |=>
      rsp_i.r_valid && $stable(rsp_i.r_id) && $stable(rsp_i.r_data) && $stable(rsp_i.r_resp))
    else $error("R payload changed before its transfer");

  one_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(grant_i))
    else $error("More than one port granted");

  r_after_ar: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_i.r_valid |-> pending_q)
    else $error("R valid without an accepted AR");

endmodule

bind read_mux interco_asserts mux_asserts_i (
  .clk_i    (clk_i    ),
  .arst_n_i (arst_n_i ),
  .req_i    (int_req_o),
  .rsp_i    (int_rsp_i),
  .grant_i  ({slv_rsp_o[3].ar_ready, slv_rsp_o[2].ar_ready,
              slv_rsp_o[1].ar_ready, slv_rsp_o[0].ar_ready})
);

bind ro_cache_ctrl interco_asserts ctrl_asserts_i (
  .clk_i    (clk_i    ),
  .arst_n_i (arst_n_i ),
  .req_i    (mst_req_o),
  .rsp_i    (mst_rsp_i),
  .grant_i  ('0       )
);

`default_nettype wire

// File: tests/interco_tb.sv
/*
 * Testbench of the read interconnect. A table of reads is applied to the
 * four ports while a memory model with random latency answers the master
 * port. Each row prints one line, a count line closes the run.
 */

`timescale 1ns/1ns
`default_nettype none

module interco_tb;

  typedef enum int {RUN_SINGLE, RUN_ALL, RUN_TIMING} run_e;

  typedef struct {
    string                name;
    int                   port;
    interco_pkg::slv_id_t id;
    interco_pkg::addr_t   addr;
    interco_pkg::data_t   key;
    int unsigned          exp_access;
    interco_pkg::rresp_e  exp_resp;
    run_e                 mode;
  } row_t;

  localparam int NumRows = 12;

  logic clk_i = 1'b0;
  logic arst_n_i;
  interco_pkg::slv_req_t [interco_pkg::NumSlvPorts-1:0] slv_req;
  interco_pkg::slv_rsp_t [interco_pkg::NumSlvPorts-1:0] slv_rsp;
  interco_pkg::int_req_t mst_req;
  interco_pkg::int_rsp_t mst_rsp;

  row_t                 rows [NumRows];
  interco_pkg::data_t   key;
  interco_pkg::data_t   ref_line [interco_pkg::addr_t]; // Lines the cache should hold
  logic [15:0]          lfsr = 16'd16388;
  int unsigned          errors = 0;
  int unsigned          failed = 0;
  int unsigned          access_count = 0;
  logic [3:0]           busy = '0;
  logic [3:0]           ready_mask = '1;   // Per-port r_ready under back-pressure
  bit                   bp_on = 1'b0;
  int unsigned          rx_count [4] = '{default: 0};
  interco_pkg::data_t   res_data [4];
  interco_pkg::rresp_e  res_resp [4];
  interco_pkg::slv_id_t res_id [4];
  int unsigned          res_lat [4];

  interco_top interco_top_i (
    .clk_i     (clk_i   ),
    .arst_n_i  (arst_n_i),
    .slv_req_i (slv_req ),
    .slv_rsp_o (slv_rsp ),
    .mst_req_o (mst_req ),
    .mst_rsp_i (mst_rsp )
  );

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Random bits and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int unsigned v);
    v = 0;
    for (int b = 0; b < n; b++) begin
      v    = (v << 1) | lfsr[0];
      lfsr = lfsr_next(lfsr);   // One step per bit
    end
  endtask

  task automatic check_data(string name, interco_pkg::data_t exp, interco_pkg::data_t act);
    if (exp !== act) begin
      $display("[ERROR] %s data expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_resp(string name, interco_pkg::rresp_e exp, interco_pkg::rresp_e act);
    if (exp !== act) begin
      $display("[ERROR] %s resp expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_id(string name, interco_pkg::slv_id_t exp, interco_pkg::slv_id_t act);
    if (exp !== act) begin
      $display("[ERROR] %s id expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(string name, int unsigned exp, int unsigned act);
    if (exp != act) begin
      $display("[ERROR] %s count expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model on the master port, data is address XOR key
  ////////////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    int unsigned          wait_cnt;
    bit                   active;
    interco_pkg::int_ar_t ar;
    mst_rsp = '0;
    active  = 1'b0;
    wait_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (!active) begin
        mst_rsp.ar_ready = 1'b1;
        mst_rsp.r_valid  = 1'b0;
      end else if (wait_cnt > 0) begin
        mst_rsp.ar_ready = 1'b0;
        wait_cnt--;
        if (wait_cnt == 0) begin
          mst_rsp.r_valid = 1'b1;
          mst_rsp.r_id    = ar.id;
          mst_rsp.r_data  = ar.addr ^ key;
          mst_rsp.r_resp  = (ar.addr >= 32'hF000_0000) ? interco_pkg::RESP_SLVERR
                                                       : interco_pkg::RESP_OKAY;
        end
      end
      #1;
      if (mst_rsp.ar_ready && mst_req.ar_valid) begin
        ar.id   = mst_req.ar_id;
        ar.addr = mst_req.ar_addr;
        access_count++;
        take_bits(2, wait_cnt);
        wait_cnt++;                 // 1 to 4 cycles
        active = 1'b1;
      end else if (mst_rsp.r_valid && mst_req.r_ready) begin
        active = 1'b0;
      end
    end
  end

  // Back-pressure pattern, one bit per port each cycle
  always @(posedge clk_i) begin : ready_draw
    int unsigned bits;
    if (bp_on) begin
      take_bits(4, bits);
      ready_mask = bits[3:0];
    end
  end

  // Port monitor, samples between the falling and rising edge
  always begin
    @(negedge clk_i);
    #1;
    for (int p = 0; p < 4; p++) begin
      if (slv_rsp[p].r_valid && !busy[p]) begin
        $display("Response seen on port %0d with no read outstanding", p);
        errors++;
      end
      if (slv_rsp[p].r_valid && slv_req[p].r_ready) rx_count[p]++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Port driver and table
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_read(input int port, input interco_pkg::slv_id_t id,
                            input interco_pkg::addr_t addr, input bit bp);
    int unsigned lat;
    int unsigned first;
    first = 0;
    @(negedge clk_i);
    busy[port] = 1'b1;
    slv_req[port].ar_valid = 1'b1;
    slv_req[port].ar_id    = id;
    slv_req[port].ar_addr  = addr;
    #1;
    while (!slv_rsp[port].ar_ready) begin
      @(negedge clk_i);
      #1;
    end
    lat = 0;
    do begin
      @(negedge clk_i);
      slv_req[port].ar_valid = 1'b0;
      slv_req[port].r_ready  = bp ? ready_mask[port] : 1'b1;
      lat++;
      #1;
      if (slv_rsp[port].r_valid && first == 0) first = lat;
    end while (!(slv_rsp[port].r_valid && slv_req[port].r_ready));
    res_data[port] = slv_rsp[port].r_data;
    res_resp[port] = slv_rsp[port].r_resp;
    res_id[port]   = slv_rsp[port].r_id;
    res_lat[port]  = first;
    @(negedge clk_i);
    slv_req[port].r_ready = 1'b0;
    busy[port] = 1'b0;
  endtask

  task automatic run_row(input row_t r);
    int unsigned        err_before;
    int unsigned        acc_before;
    int unsigned        rx_before [4];
    interco_pkg::data_t exp;
    err_before = errors;
    acc_before = access_count;
    rx_before  = rx_count;
    key        = r.key;
    if (r.mode == RUN_ALL) begin
      bp_on = 1'b1;
      for (int p = 0; p < 4; p++) begin
        automatic int pp = p;
        fork
          issue_read(pp, interco_pkg::slv_id_t'(pp), r.addr + 4 * pp, 1'b1);
        join_none
      end
      wait fork;
      bp_on = 1'b0;
      for (int p = 0; p < 4; p++) begin
        check_data(r.name, (r.addr + 4 * p) ^ r.key, res_data[p]);
        check_resp(r.name, r.exp_resp, res_resp[p]);
        check_id(r.name, interco_pkg::slv_id_t'(p), res_id[p]);
        check_count({r.name, " responses"}, 1, rx_count[p] - rx_before[p]);
        ref_line[r.addr + 4 * p] = (r.addr + 4 * p) ^ r.key;
      end
      check_count({r.name, " accesses"}, r.exp_access, access_count - acc_before);
    end else begin
      issue_read(r.port, r.id, r.addr, 1'b0);
      exp = (r.exp_access == 0 && ref_line.exists(r.addr)) ? ref_line[r.addr]
                                                           : r.addr ^ r.key;
      check_data(r.name, exp, res_data[r.port]);
      check_resp(r.name, r.exp_resp, res_resp[r.port]);
      check_id(r.name, r.id, res_id[r.port]);
      check_count({r.name, " accesses"}, r.exp_access, access_count - acc_before);
      check_count({r.name, " responses"}, 1, rx_count[r.port] - rx_before[r.port]);
      if (r.mode == RUN_TIMING) check_count({r.name, " latency"}, 3, res_lat[r.port]);
      // Only window reads with OKAY are kept
      if (r.exp_access != 0 && r.exp_resp == interco_pkg::RESP_OKAY &&
          r.addr >= interco_pkg::CacheBase && r.addr < interco_pkg::CacheLimit) begin
        ref_line[r.addr] = r.addr ^ r.key;
      end
    end
    if (errors != err_before) failed++;
    $display("%s %s", (errors != err_before) ? "FAIL" : "PASS", r.name);
  endtask

  initial begin : watchdog
    repeat (NumRows * 40 + 3) @(posedge clk_i);
    $display("Watchdog expired before all tests finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    slv_req  = '0;
    arst_n_i = 1'b0;
    key      = '0;
    rows[0]  = '{"miss_fill", 0, 2'd1, 32'h1000_0010, 32'hA5A5_5A5A, 1,
                 interco_pkg::RESP_OKAY, RUN_SINGLE};
    rows[1]  = '{"hit_repeat", 0, 2'd1, 32'h1000_0010, 32'hA5A5_5A5A, 0,
                 interco_pkg::RESP_OKAY, RUN_SINGLE};
    rows[2]  = '{"stale_cached", 1, 2'd2, 32'h1000_0010, 32'h0F0F_F0F0, 0,
                 interco_pkg::RESP_OKAY, RUN_SINGLE};
    rows[3]  = '{"bypass_new_key", 1, 2'd2, 32'h2000_0040, 32'h0F0F_F0F0, 1,
                 interco_pkg::RESP_OKAY, RUN_SINGLE};
    rows[4]  = '{"slverr_first", 2, 2'd3, 32'hF000_0000, 32'h0F0F_F0F0, 1,
                 interco_pkg::RESP_SLVERR, RUN_SINGLE};
    rows[5]  = '{"slverr_repeat", 2, 2'd3, 32'hF000_0000, 32'h0F0F_F0F0, 1,
                 interco_pkg::RESP_SLVERR, RUN_SINGLE};
    rows[6]  = '{"route_port0", 0, 2'd3, 32'h2000_0100, 32'h0000_FFFF, 1,
                 interco_pkg::RESP_OKAY, RUN_SINGLE};
    rows[7]  = '{"route_port1", 1, 2'd2, 32'h2000_0104, 32'h0000_FFFF, 1,
                 interco_pkg::RESP_OKAY, RUN_SINGLE};
    rows[8]  = '{"route_port2", 2, 2'd1, 32'h2000_0108, 32'h0000_FFFF, 1,
                 interco_pkg::RESP_OKAY, RUN_SINGLE};
    rows[9]  = '{"route_port3", 3, 2'd0, 32'h2000_010C, 32'h0000_FFFF, 1,
                 interco_pkg::RESP_OKAY, RUN_SINGLE};
    rows[10] = '{"contention", 0, 2'd0, 32'h1000_0200, 32'h1234_5678, 4,
                 interco_pkg::RESP_OKAY, RUN_ALL};
    rows[11] = '{"hit_timing", 3, 2'd0, 32'h1000_0010, 32'h1234_5678, 0,
                 interco_pkg::RESP_OKAY, RUN_TIMING};
    repeat (3) @(negedge clk_i);
    arst_n_i = 1'b1;
    for (int i = 0; i < NumRows; i++) run_row(rows[i]);
    $display("Tests: %0d run, %0d failed, %0d errors", NumRows, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
